//--- design/div_cfg_pkg.sv
package div_cfg_pkg;

    // Operand and result width.
    localparam int xlen = 32;

    // Width of the caller's operation tag.
    localparam int tag_width = 4;

    // Register stages inside each divider core.
    localparam int div_stages = 2;

    // Strobe in to strobe out.
    // The result stage adds one register after the cores.
    localparam int div_latency = div_stages + 1;

endpackage

//--- design/div_types_pkg.sv
package div_types_pkg;

    // Low two bits of the RISC-V M extension funct3 for the divide group.
    typedef enum logic [1:0] {
        op_div  = 2'b00,
        op_divu = 2'b01,
        op_rem  = 2'b10,
        op_remu = 2'b11
    } div_op_e;

    // Signed operand representation.
    function automatic logic op_is_signed(div_op_e op);
        return (op == op_div) || (op == op_rem);
    endfunction

    // Remainder rather than quotient.
    function automatic logic op_is_rem(div_op_e op);
        return (op == op_rem) || (op == op_remu);
    endfunction

endpackage

//--- design/div_core.sv
`timescale 1ns/1ps

module div_core #(
    parameter int signed_mode = 0
) (
    input  logic                         clock,
    input  logic                         aclr,
    input  logic [div_cfg_pkg::xlen-1:0] numer,
    input  logic [div_cfg_pkg::xlen-1:0] denom,
    output logic [div_cfg_pkg::xlen-1:0] quotient,
    output logic [div_cfg_pkg::xlen-1:0] remainder
);

    import div_cfg_pkg::*;

    localparam logic [xlen-1:0] all_ones = {xlen{1'b1}};
    localparam logic [xlen-1:0] int_min  = {1'b1, {(xlen-1){1'b0}}};

    // Operand delay line, one entry per stage.
    logic [xlen-1:0] numer_q [div_stages];
    logic [xlen-1:0] denom_q [div_stages];

    logic [xlen-1:0] num_end;
    logic [xlen-1:0] den_end;
    logic            div_zero;
    logic            overflow;

    always_ff @(posedge clock or posedge aclr) begin
        if (aclr) begin
            for (int i = 0; i < div_stages; i++) begin
                numer_q[i] <= '0;
                denom_q[i] <= '0;
            end
        end else begin
            numer_q[0] <= numer;
            denom_q[0] <= denom;
            for (int i = 1; i < div_stages; i++) begin
                numer_q[i] <= numer_q[i-1];
                denom_q[i] <= denom_q[i-1];
            end
        end
    end

    assign num_end = numer_q[div_stages-1];
    assign den_end = denom_q[div_stages-1];

    assign div_zero = (den_end == '0);

    // Only the signed form can overflow.
    assign overflow = (signed_mode != 0) && (num_end == int_min) && (den_end == all_ones);

    generate
        if (signed_mode != 0) begin : g_signed
            // Truncating division; the remainder keeps the numerator's sign.
            always_comb begin
                if (div_zero) begin
                    quotient  = all_ones;
                    remainder = num_end;
                end else if (overflow) begin
                    // The quotient wraps back to the numerator.
                    quotient  = num_end;
                    remainder = '0;
                end else begin
                    quotient  = $signed(num_end) / $signed(den_end);
                    remainder = $signed(num_end) % $signed(den_end);
                end
            end
        end else begin : g_unsigned
            always_comb begin
                if (div_zero) begin
                    quotient  = all_ones;
                    remainder = num_end;
                end else begin
                    quotient  = num_end / den_end;
                    remainder = num_end % den_end;
                end
            end
        end
    endgenerate

    // Division identity, modulo 2**xlen, which holds for both representations.
    a_div_identity: assert property (
        @(posedge clock) disable iff (aclr)
        (!div_zero && !overflow) |-> ((quotient * den_end + remainder) == num_end)
    ) else $error("div_core: quotient * denom + remainder differs from numer");

endmodule

//--- design/div_ctrl_pipe.sv
`timescale 1ns/1ps

module div_ctrl_pipe (
    input  logic                              clock,
    input  logic                              aclr,
    input  logic                              in_valid,
    input  div_types_pkg::div_op_e            op,
    input  logic [div_cfg_pkg::tag_width-1:0] tag,
    output logic                              pipe_valid,
    output div_types_pkg::div_op_e            pipe_op,
    output logic [div_cfg_pkg::tag_width-1:0] pipe_tag
);

    import div_cfg_pkg::*;
    import div_types_pkg::*;

    // One entry per divider stage.
    logic                 valid_q [div_stages];
    div_op_e              op_q    [div_stages];
    logic [tag_width-1:0] tag_q   [div_stages];

    always_ff @(posedge clock or posedge aclr) begin
        if (aclr) begin
            for (int i = 0; i < div_stages; i++) begin
                valid_q[i] <= 1'b0;
                op_q[i]    <= op_div;
                tag_q[i]   <= '0;
            end
        end else begin
            valid_q[0] <= in_valid;
            if (in_valid) begin
                op_q[0]  <= op;
                tag_q[0] <= tag;
            end
            // Payload moves only behind a valid entry.
            for (int i = 1; i < div_stages; i++) begin
                valid_q[i] <= valid_q[i-1];
                if (valid_q[i-1]) begin
                    op_q[i]  <= op_q[i-1];
                    tag_q[i] <= tag_q[i-1];
                end
            end
        end
    end

    assign pipe_valid = valid_q[div_stages-1];
    assign pipe_op    = op_q[div_stages-1];
    assign pipe_tag   = tag_q[div_stages-1];

    // A floating strobe upstream would show up here.
    a_valid_known: assert property (
        @(posedge clock) disable iff (aclr)
        !$isunknown(pipe_valid)
    ) else $error("div_ctrl_pipe: pipe_valid is unknown");

endmodule

//--- design/div_result_mux.sv
`timescale 1ns/1ps

module div_result_mux (
    input  logic                              clock,
    input  logic                              aclr,
    input  logic                              pipe_valid,
    input  div_types_pkg::div_op_e            pipe_op,
    input  logic [div_cfg_pkg::tag_width-1:0] pipe_tag,
    input  logic [div_cfg_pkg::xlen-1:0]      sq,
    input  logic [div_cfg_pkg::xlen-1:0]      sr,
    input  logic [div_cfg_pkg::xlen-1:0]      uq,
    input  logic [div_cfg_pkg::xlen-1:0]      ur,
    output logic                              out_valid,
    output logic [div_cfg_pkg::xlen-1:0]      result,
    output logic [div_cfg_pkg::tag_width-1:0] out_tag
);

    import div_cfg_pkg::*;
    import div_types_pkg::*;

    logic [xlen-1:0] sel_quot;
    logic [xlen-1:0] sel_rem;
    logic [xlen-1:0] sel_result;

    // Pick the core first, then quotient or remainder.
    always_comb begin
        if (op_is_signed(pipe_op)) begin
            sel_quot = sq;
            sel_rem  = sr;
        end else begin
            sel_quot = uq;
            sel_rem  = ur;
        end
        sel_result = op_is_rem(pipe_op) ? sel_rem : sel_quot;
    end

    always_ff @(posedge clock or posedge aclr) begin
        if (aclr) begin
            out_valid <= 1'b0;
            result    <= '0;
            out_tag   <= '0;
        end else begin
            out_valid <= pipe_valid;
            // Hold the last result while idle.
            if (pipe_valid) begin
                result  <= sel_result;
                out_tag <= pipe_tag;
            end
        end
    end

    // Opcode carried down the control pipe must be a known encoding.
    a_op_legal: assert property (
        @(posedge clock) disable iff (aclr)
        pipe_valid |-> !$isunknown(pipe_op)
    ) else $error("div_result_mux: unknown opcode with pipe_valid high");

endmodule

//--- design/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic                              clock,
    input  logic                              aclr,
    input  logic                              in_valid,
    input  logic [div_cfg_pkg::xlen-1:0]      numer,
    input  logic [div_cfg_pkg::xlen-1:0]      denom,
    input  div_types_pkg::div_op_e            op,
    input  logic [div_cfg_pkg::tag_width-1:0] tag,
    output logic                              out_valid,
    output logic [div_cfg_pkg::xlen-1:0]      result,
    output logic [div_cfg_pkg::tag_width-1:0] out_tag
);

    import div_cfg_pkg::*;
    import div_types_pkg::*;

    // Signed core results.
    logic [xlen-1:0] sq;
    logic [xlen-1:0] sr;

    // Unsigned core results.
    logic [xlen-1:0] uq;
    logic [xlen-1:0] ur;

    // Control aligned with the core outputs.
    logic                 pipe_valid;
    div_op_e              pipe_op;
    logic [tag_width-1:0] pipe_tag;

    // Both cores see every operand pair.
    div_core #(
        .signed_mode (1)
    ) i_div_signed (
        .clock     (clock),
        .aclr      (aclr),
        .numer     (numer),
        .denom     (denom),
        .quotient  (sq),
        .remainder (sr)
    );

    div_core #(
        .signed_mode (0)
    ) i_div_unsigned (
        .clock     (clock),
        .aclr      (aclr),
        .numer     (numer),
        .denom     (denom),
        .quotient  (uq),
        .remainder (ur)
    );

    div_ctrl_pipe i_div_ctrl_pipe (
        .clock      (clock),
        .aclr       (aclr),
        .in_valid   (in_valid),
        .op         (op),
        .tag        (tag),
        .pipe_valid (pipe_valid),
        .pipe_op    (pipe_op),
        .pipe_tag   (pipe_tag)
    );

    div_result_mux i_div_result_mux (
        .clock      (clock),
        .aclr       (aclr),
        .pipe_valid (pipe_valid),
        .pipe_op    (pipe_op),
        .pipe_tag   (pipe_tag),
        .sq         (sq),
        .sr         (sr),
        .uq         (uq),
        .ur         (ur),
        .out_valid  (out_valid),
        .result     (result),
        .out_tag    (out_tag)
    );

endmodule

//--- tb/tb_div_unit.sv
`timescale 1ns/1ps

module tb_div_unit;

    import div_cfg_pkg::*;
    import div_types_pkg::*;

    localparam int clock_period = 100;
    localparam int reset_cycles = 5;

    // Operations issued by each test phase.
    localparam int n_random   = 200;
    localparam int n_zero     = 24;
    localparam int n_overflow = 4;
    localparam int n_mixed    = 96;
    localparam int n_gapped   = 100;
    localparam int n_midrun   = 23;
    localparam int n_ops      = n_random + n_zero + n_overflow + n_mixed + n_gapped + n_midrun;

    // At most two cycles per operation, two resets, the drain and some margin.
    localparam int timeout_cycles = 2 * n_ops + 2 * reset_cycles + div_latency + 50;

    localparam logic [xlen-1:0] all_ones = {xlen{1'b1}};
    localparam logic [xlen-1:0] int_min  = {1'b1, {(xlen-1){1'b0}}};

    logic                 clock;
    logic                 aclr;
    logic                 in_valid;
    logic [xlen-1:0]      numer;
    logic [xlen-1:0]      denom;
    div_op_e              op;
    logic [tag_width-1:0] tag;
    logic                 out_valid;
    logic [xlen-1:0]      result;
    logic [tag_width-1:0] out_tag;

    integer seed            = 32'hc2d1;
    int     cycle_count     = 0;
    int     op_count        = 0;
    int     checked_count   = 0;
    int     value_errors    = 0;
    int     protocol_errors = 0;
    logic   aclr_seen       = 1'b0;

    // Operations in flight, oldest first.
    logic [xlen-1:0]      exp_numer_q[$];
    logic [xlen-1:0]      exp_denom_q[$];
    div_op_e              exp_op_q[$];
    logic [xlen-1:0]      exp_result_q[$];
    logic [tag_width-1:0] exp_tag_q[$];
    int                   exp_cycle_q[$];

    div_unit i_div_unit (
        .clock     (clock),
        .aclr      (aclr),
        .in_valid  (in_valid),
        .numer     (numer),
        .denom     (denom),
        .op        (op),
        .tag       (tag),
        .out_valid (out_valid),
        .result    (result),
        .out_tag   (out_tag)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // Expected value by the M extension rules, worked on magnitudes for signed operands.
    function automatic logic [xlen-1:0] expected_result(
        input logic [xlen-1:0] a,
        input logic [xlen-1:0] b,
        input div_op_e         o
    );
        logic            is_signed;
        logic            want_rem;
        logic [xlen-1:0] mag_a;
        logic [xlen-1:0] mag_b;
        logic [xlen-1:0] q;
        logic [xlen-1:0] r;
        case (o)
            op_div: begin
                is_signed = 1'b1;
                want_rem  = 1'b0;
            end
            op_divu: begin
                is_signed = 1'b0;
                want_rem  = 1'b0;
            end
            op_rem: begin
                is_signed = 1'b1;
                want_rem  = 1'b1;
            end
            op_remu: begin
                is_signed = 1'b0;
                want_rem  = 1'b1;
            end
        endcase
        if (b == '0) begin
            q = all_ones;
            r = a;
        end else if (is_signed && a == int_min && b == all_ones) begin
            q = a;
            r = '0;
        end else if (is_signed) begin
            mag_a = a[xlen-1] ? -a : a;
            mag_b = b[xlen-1] ? -b : b;
            q = mag_a / mag_b;
            r = mag_a % mag_b;
            // Quotient sign from both operands, remainder sign from the numerator.
            if (a[xlen-1] ^ b[xlen-1]) q = -q;
            if (a[xlen-1]) r = -r;
        end else begin
            q = a / b;
            r = a % b;
        end
        return want_rem ? r : q;
    endfunction

    function automatic logic [xlen-1:0] with_sign(input logic [xlen-1:0] mag, input logic neg);
        return neg ? -mag : mag;
    endfunction

    function automatic logic [xlen-1:0] edge_numer(input int idx);
        case (idx)
            0:       return '0;
            1:       return {{(xlen-1){1'b0}}, 1'b1};
            2:       return ~int_min;
            3:       return int_min;
            4:       return all_ones;
            default: return 32'h0001_e240;
        endcase
    endfunction

    task automatic send_op(input logic [xlen-1:0] a, input logic [xlen-1:0] b, input div_op_e o);
        @(negedge clock);
        in_valid = 1'b1;
        numer    = a;
        denom    = b;
        op       = o;
        tag      = op_count[tag_width-1:0];
        exp_numer_q.push_back(a);
        exp_denom_q.push_back(b);
        exp_op_q.push_back(o);
        exp_result_q.push_back(expected_result(a, b, o));
        exp_tag_q.push_back(op_count[tag_width-1:0]);
        exp_cycle_q.push_back(cycle_count + div_latency);
        op_count++;
    endtask

    // Idle cycle with noise on the operand inputs.
    task automatic idle_cycle();
        logic [xlen-1:0] r;
        @(negedge clock);
        r        = $random(seed);
        in_valid = 1'b0;
        numer    = r;
        denom    = ~r;
        op       = div_op_e'(r[1:0]);
        tag      = r[tag_width-1:0];
    endtask

    task automatic random_op();
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] r;
        a = $random(seed);
        b = $random(seed);
        r = $random(seed);
        // Bias towards small divisors and the edge operands.
        if (r[3:0] == 4'h0) begin
            b = '0;
        end else if (r[3:2] == 2'b00) begin
            b = {{(xlen-4){r[7]}}, r[7:4]};
        end
        if (r[15:12] == 4'h0) a = int_min;
        if (r[19:16] == 4'h0) b = all_ones;
        send_op(a, b, div_op_e'(r[9:8]));
    endtask

    task automatic mixed_sign_ops(input logic neg_numer);
        logic [xlen-1:0] r;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        r = $random(seed);
        a = with_sign({1'b0, r[xlen-2:0]}, neg_numer);
        r = $random(seed);
        b = with_sign({{(xlen-5){1'b0}}, r[4:0] | 5'd1}, !neg_numer);
        for (int k = 0; k < 4; k++) begin
            send_op(a, b, div_op_e'(k[1:0]));
        end
    endtask

    task automatic apply_reset();
        @(negedge clock);
        aclr     = 1'b1;
        in_valid = 1'b0;
        repeat (reset_cycles) @(negedge clock);
        aclr = 1'b0;
    endtask

    task automatic pop_expected(
        output logic [xlen-1:0]      a,
        output logic [xlen-1:0]      b,
        output div_op_e              o,
        output logic [xlen-1:0]      res,
        output logic [tag_width-1:0] t,
        output int                   cyc
    );
        a   = exp_numer_q.pop_front();
        b   = exp_denom_q.pop_front();
        o   = exp_op_q.pop_front();
        res = exp_result_q.pop_front();
        t   = exp_tag_q.pop_front();
        cyc = exp_cycle_q.pop_front();
    endtask

    task automatic flush_expected();
        exp_numer_q.delete();
        exp_denom_q.delete();
        exp_op_q.delete();
        exp_result_q.delete();
        exp_tag_q.delete();
        exp_cycle_q.delete();
    endtask

    // Each result strobe retires the oldest operation in flight.
    always @(negedge clock) begin
        logic [xlen-1:0]      e_numer;
        logic [xlen-1:0]      e_denom;
        div_op_e              e_op;
        logic [xlen-1:0]      e_result;
        logic [tag_width-1:0] e_tag;
        int                   e_cycle;
        if (aclr) begin
            if (aclr_seen) begin
                assert (out_valid === 1'b0) else begin
                    protocol_errors++;
                    $display("Result strobe seen while reset was asserted at %0t ns", $time);
                end
            end
            // Reset drops everything in flight.
            flush_expected();
            aclr_seen = 1'b1;
        end else begin
            aclr_seen = 1'b0;
            if (out_valid === 1'b1) begin
                assert (exp_cycle_q.size() != 0) else begin
                    protocol_errors++;
                    $display("Result strobe at %0t ns with no operation in flight", $time);
                end
                if (exp_cycle_q.size() != 0) begin
                    pop_expected(e_numer, e_denom, e_op, e_result, e_tag, e_cycle);
                    checked_count++;
                    assert (cycle_count == e_cycle) else begin
                        value_errors++;
                        $display("ERR %0t ns: tag %0d arrived in cycle %0d, expected cycle %0d",
                                 $time, e_tag, cycle_count, e_cycle);
                    end
                    assert (result === e_result) else begin
                        value_errors++;
                        $display("ERR %0t ns: wrong result for %s %h, %h: got %h, expected %h",
                                 $time, e_op.name(), e_numer, e_denom, result, e_result);
                    end
                    assert (out_tag === e_tag) else begin
                        value_errors++;
                        $display("ERR %0t ns: wrong tag: got %0d, expected %0d",
                                 $time, out_tag, e_tag);
                    end
                end
            end else if (exp_cycle_q.size() != 0) begin
                assert (exp_cycle_q[0] > cycle_count) else begin
                    protocol_errors++;
                    $display("Result for tag %0d did not arrive by %0t ns", exp_tag_q[0], $time);
                    pop_expected(e_numer, e_denom, e_op, e_result, e_tag, e_cycle);
                end
            end
        end
    end

    initial begin
        while (cycle_count < timeout_cycles) @(posedge clock);
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [xlen-1:0] r;
        aclr     = 1'b1;
        in_valid = 1'b0;
        numer    = '0;
        denom    = '0;
        op       = op_div;
        tag      = '0;
        apply_reset();

        // Back-to-back random traffic.
        repeat (n_random) random_op();

        // Division by zero with every opcode.
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 4; k++) begin
                send_op(edge_numer(i), '0, div_op_e'(k[1:0]));
            end
        end

        // Most negative value over minus one.
        for (int k = 0; k < 4; k++) begin
            send_op(int_min, all_ones, div_op_e'(k[1:0]));
        end

        // 7 and 2 in all four sign combinations.
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k++) begin
                send_op(with_sign(7, i[0]), with_sign(2, i[1]), div_op_e'(k[1:0]));
            end
        end
        for (int i = 0; i < 20; i++) begin
            mixed_sign_ops(i[0]);
        end

        // Strobes with random idle gaps.
        for (int i = 0; i < n_gapped; i++) begin
            random_op();
            r = $random(seed);
            if (r[0]) idle_cycle();
        end

        // Reset with operations still in the pipe.
        repeat (3) random_op();
        apply_reset();
        repeat (20) random_op();

        while (exp_cycle_q.size() != 0) idle_cycle();
        repeat (div_latency + 2) idle_cycle();

        $display("Checked %0d results from %0d operations: %0d value errors, %0d protocol errors",
                 checked_count, op_count, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
design/div_cfg_pkg.sv
design/div_types_pkg.sv
design/div_core.sv
design/div_ctrl_pipe.sv
design/div_result_mux.sv
design/div_unit.sv
tb/tb_div_unit.sv

//--- Makefile
TOP := tb_div_unit
OBJ := obj_dir
LOG := sim.log

SRCS := $(shell cat flist.f)

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): flist.f $(SRCS)
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir $(OBJ)

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only -Wall --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) $(LOG)
